/* common/mem_front_config.svh */
`ifndef MEM_FRONT_CONFIG_SVH
`define MEM_FRONT_CONFIG_SVH

////////////////////////////////////////
// word and block widths
////////////////////////////////////////

// one word, address and instruction
`define MF_XLEN       32
// one memory block, two words
`define MF_BLOCK_BITS 64

////////////////////////////////////////
// memory tags and queue sizing
////////////////////////////////////////

// tag 0 reserved, means none or rejected
`define MF_TAG_BITS   4
`define MF_NUM_TAGS   16

`define MF_LSQ_DEPTH  4
// request id carried through the queue
`define MF_ID_BITS    4

// first fetch address
`define MF_RESET_PC   32'h0000_0000

`endif

/* common/mem_front_pkg.sv */
`include "mem_front_config.svh"

package mem_front_pkg;

    ////////////////////////////////////////
    // memory bus command
    ////////////////////////////////////////

    // same encoding as the memory model
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    ////////////////////////////////////////
    // one memory block, two views
    ////////////////////////////////////////

    // dword: whole block, as the queue sees it
    // words: two instructions, picked by addr bit 2
    typedef union packed {
        logic [`MF_BLOCK_BITS-1:0]   dword;
        logic [1:0][`MF_XLEN-1:0]    words;
    } mem_block_t;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/100ps
`include "mem_front_config.svh"

module fetch_unit (
    input  logic                      clock,
    input  logic                      reset,

    // block request toward the arbiter
    output logic                      fetch_req_valid,
    input  logic                      fetch_req_ready,
    output logic [`MF_XLEN-1:0]       fetch_addr,

    // block return, already matched by the arbiter
    input  logic                      fetch_ret_valid,
    input  mem_front_pkg::mem_block_t ret_block,

    // one instruction at a time
    output logic                      inst_valid,
    input  logic                      inst_ready,
    output logic [`MF_XLEN-1:0]       inst,
    output logic [`MF_XLEN-1:0]       inst_pc
);

    // request -> wait for block -> hold word until taken
    typedef enum logic [1:0] {
        ST_REQ,
        ST_WAIT,
        ST_HOLD
    } fetch_state_t;

    fetch_state_t        state;
    logic [`MF_XLEN-1:0] pc;
    logic [`MF_XLEN-1:0] inst_q;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    // only one block in flight, none while in reset
    assign fetch_req_valid = (state == ST_REQ) && !reset;
    // block aligned, low three bits cleared
    assign fetch_addr      = {pc[`MF_XLEN-1:3], 3'b000};

    ////////////////////////////////////////
    // hand-off side
    ////////////////////////////////////////
    assign inst_valid = (state == ST_HOLD);
    assign inst       = inst_q;
    assign inst_pc    = pc;

    // pc and state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ST_REQ;
            pc    <= `MF_RESET_PC;
        end else begin
            case (state)
                ST_REQ: begin
                    // arbiter took it, memory gave a tag
                    if (fetch_req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (fetch_ret_valid) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // taken, step to the next word
                    if (inst_ready) begin
                        pc    <= pc + `MF_XLEN'(4);
                        state <= ST_REQ;
                    end
                end
                default: begin
                    state <= ST_REQ;
                end
            endcase
        end
    end

    // word capture, pc bit 2 picks the half
    always_ff @(posedge clock) begin
        if (state == ST_WAIT && fetch_ret_valid) begin
            inst_q <= ret_block.words[pc[2]];
        end
    end

endmodule

/* lsq/lsq.sv */
`timescale 1ns/100ps
`include "mem_front_config.svh"

module lsq (
    input  logic                        clock,
    input  logic                        reset,

    // requests in program order
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_store,
    input  logic [`MF_XLEN-1:0]         req_addr,
    input  mem_front_pkg::mem_block_t   req_data,
    input  logic [`MF_ID_BITS-1:0]      req_id,

    // head request toward the arbiter
    output logic                        data_req_valid,
    input  logic                        data_req_ready,
    output mem_front_pkg::bus_command_t data_command,
    output logic [`MF_XLEN-1:0]         data_addr,
    output mem_front_pkg::mem_block_t   data_wdata,

    // load data back from the arbiter
    input  logic                        data_ret_valid,
    input  mem_front_pkg::mem_block_t   ret_block,

    // load results out
    output logic                        load_valid,
    input  logic                        load_ready,
    output mem_front_pkg::mem_block_t   load_data,
    output logic [`MF_ID_BITS-1:0]      load_id
);

    localparam int PTR_BITS = $clog2(`MF_LSQ_DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(`MF_LSQ_DEPTH - 1);

    ////////////////////////////////////////
    // entry storage, no reset
    ////////////////////////////////////////
    logic                      ent_store [`MF_LSQ_DEPTH];
    logic [`MF_XLEN-1:0]       ent_addr  [`MF_LSQ_DEPTH];
    mem_front_pkg::mem_block_t ent_data  [`MF_LSQ_DEPTH];
    logic [`MF_ID_BITS-1:0]    ent_id    [`MF_LSQ_DEPTH];

    // pointers and fill level
    logic [PTR_BITS-1:0] head_ptr;
    logic [PTR_BITS-1:0] tail_ptr;
    logic [PTR_BITS:0]   count;

    // head load progress
    logic head_wait;
    logic head_done;

    logic push;
    logic pop;
    logic issue;

    assign req_ready = (count != (PTR_BITS+1)'(`MF_LSQ_DEPTH));
    assign push      = req_valid && req_ready;
    // only an idle head goes to memory
    assign data_req_valid = (count != '0) && !head_wait && !head_done;
    assign issue          = data_req_valid && data_req_ready;

    assign data_command = ent_store[head_ptr] ? mem_front_pkg::BUS_STORE
                                              : mem_front_pkg::BUS_LOAD;
    assign data_addr    = ent_addr[head_ptr];
    assign data_wdata   = ent_data[head_ptr];

    // returned load, shown from the cycle after data_ret_valid
    assign load_valid = head_done;
    assign load_data  = ent_data[head_ptr];
    assign load_id    = ent_id[head_ptr];

    // stores leave on acceptance, loads on hand-off
    assign pop = (issue && ent_store[head_ptr]) || (load_valid && load_ready);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count     <= '0;
            head_wait <= 1'b0;
            head_done <= 1'b0;
        end else begin
            if (push) begin
                tail_ptr <= (tail_ptr == LAST_SLOT) ? '0 : tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= (head_ptr == LAST_SLOT) ? '0 : head_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // load accepted, now waiting on its tag
            if (issue && !ent_store[head_ptr]) begin
                head_wait <= 1'b1;
            end
            if (head_wait && data_ret_valid) begin
                head_wait <= 1'b0;
                head_done <= 1'b1;
            end
            if (load_valid && load_ready) begin
                head_done <= 1'b0;
            end
        end
    end

    // entry writes
    // tail slot on push, head data on load return
    // both never hit the same slot, queue is neither empty nor full then
    always_ff @(posedge clock) begin
        if (push) begin
            ent_store[tail_ptr] <= req_store;
            ent_addr[tail_ptr]  <= req_addr;
            ent_data[tail_ptr]  <= req_data;
            ent_id[tail_ptr]    <= req_id;
        end
        if (head_wait && data_ret_valid) begin
            ent_data[head_ptr].dword <= ret_block.dword;
        end
    end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/100ps
`include "mem_front_config.svh"

module mem_arbiter (
    input  logic                        clock,
    input  logic                        reset,

    // fetch requester, loads only
    input  logic                        fetch_req_valid,
    output logic                        fetch_req_ready,
    input  logic [`MF_XLEN-1:0]         fetch_addr,

    // data requester from the queue
    input  logic                        data_req_valid,
    output logic                        data_req_ready,
    input  mem_front_pkg::bus_command_t data_command,
    input  logic [`MF_XLEN-1:0]         data_addr,
    input  mem_front_pkg::mem_block_t   data_wdata,

    // routed returns
    output logic                        fetch_ret_valid,
    output logic                        data_ret_valid,
    output mem_front_pkg::mem_block_t   ret_block,

    // memory port
    input  logic [`MF_TAG_BITS-1:0]     mem_response,
    input  logic [`MF_TAG_BITS-1:0]     mem_tag,
    input  mem_front_pkg::mem_block_t   mem_data_in,
    output mem_front_pkg::bus_command_t mem_command,
    output logic [`MF_XLEN-1:0]         mem_addr,
    output mem_front_pkg::mem_block_t   mem_data
);

    // who is waiting on each tag
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA
    } owner_t;

    owner_t owner_q [`MF_NUM_TAGS];
    owner_t ret_owner;
    logic   accepted;

    ////////////////////////////////////////
    // request mux, data side wins
    ////////////////////////////////////////
    always_comb begin
        mem_command = mem_front_pkg::BUS_NONE;
        mem_addr    = data_addr;
        mem_data    = data_wdata;
        if (data_req_valid) begin
            mem_command = data_command;
        end else if (fetch_req_valid) begin
            // fetch only ever reads
            mem_command = mem_front_pkg::BUS_LOAD;
            mem_addr    = fetch_addr;
            mem_data    = '0;
        end
    end

    // nonzero response = accepted this cycle
    assign accepted        = (mem_response != '0);
    assign data_req_ready  = data_req_valid && accepted;
    assign fetch_req_ready = !data_req_valid && fetch_req_valid && accepted;

    ////////////////////////////////////////
    // return routing
    ////////////////////////////////////////
    assign ret_owner       = owner_q[mem_tag];
    assign ret_block       = mem_data_in;
    assign fetch_ret_valid = (mem_tag != '0) && (ret_owner == OWN_FETCH);
    assign data_ret_valid  = (mem_tag != '0) && (ret_owner == OWN_DATA);

    // owner table
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MF_NUM_TAGS; i++) begin
                owner_q[i] <= OWN_NONE;
            end
        end else begin
            // retire the tag whose data just came back
            if (mem_tag != '0) begin
                owner_q[mem_tag] <= OWN_NONE;
            end
            // new load claims its tag, wins over a same-tag clear
            if (data_req_ready && data_command == mem_front_pkg::BUS_LOAD) begin
                owner_q[mem_response] <= OWN_DATA;
            end else if (fetch_req_ready) begin
                owner_q[mem_response] <= OWN_FETCH;
            end
        end
    end

endmodule

/* hdl/mem_front_top.sv */
`timescale 1ns/100ps
`include "mem_front_config.svh"

module mem_front_top (
    input  logic                        clock,
    input  logic                        reset,

    // shared memory port
    input  logic [`MF_TAG_BITS-1:0]     mem_response,
    input  logic [`MF_TAG_BITS-1:0]     mem_tag,
    input  mem_front_pkg::mem_block_t   mem_data_in,
    output mem_front_pkg::bus_command_t mem_command,
    output logic [`MF_XLEN-1:0]         mem_addr,
    output mem_front_pkg::mem_block_t   mem_data,

    // instruction stream out
    output logic                        inst_valid,
    input  logic                        inst_ready,
    output logic [`MF_XLEN-1:0]         inst,
    output logic [`MF_XLEN-1:0]         inst_pc,

    // load/store requests in
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_store,
    input  logic [`MF_XLEN-1:0]         req_addr,
    input  mem_front_pkg::mem_block_t   req_data,
    input  logic [`MF_ID_BITS-1:0]      req_id,

    // load results out
    output logic                        load_valid,
    input  logic                        load_ready,
    output mem_front_pkg::mem_block_t   load_data,
    output logic [`MF_ID_BITS-1:0]      load_id
);

    ////////////////////////////////////////
    // fetch side wires
    ////////////////////////////////////////
    logic                        fetch_req_valid;
    logic                        fetch_req_ready;
    logic [`MF_XLEN-1:0]         fetch_addr;
    logic                        fetch_ret_valid;

    ////////////////////////////////////////
    // data side wires
    ////////////////////////////////////////
    logic                        data_req_valid;
    logic                        data_req_ready;
    mem_front_pkg::bus_command_t data_command;
    logic [`MF_XLEN-1:0]         data_addr;
    mem_front_pkg::mem_block_t   data_wdata;
    logic                        data_ret_valid;

    // returned block, shared by both requesters
    mem_front_pkg::mem_block_t   ret_block;

    fetch_unit i_fetch (
        .clock           (clock),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_addr      (fetch_addr),
        .fetch_ret_valid (fetch_ret_valid),
        .ret_block       (ret_block),
        .inst_valid      (inst_valid),
        .inst_ready      (inst_ready),
        .inst            (inst),
        .inst_pc         (inst_pc)
    );

    lsq i_lsq (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_store      (req_store),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .req_id         (req_id),
        .data_req_valid (data_req_valid),
        .data_req_ready (data_req_ready),
        .data_command   (data_command),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_ret_valid (data_ret_valid),
        .ret_block      (ret_block),
        .load_valid     (load_valid),
        .load_ready     (load_ready),
        .load_data      (load_data),
        .load_id        (load_id)
    );

    mem_arbiter i_arbiter (
        .clock           (clock),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_addr      (fetch_addr),
        .data_req_valid  (data_req_valid),
        .data_req_ready  (data_req_ready),
        .data_command    (data_command),
        .data_addr       (data_addr),
        .data_wdata      (data_wdata),
        .fetch_ret_valid (fetch_ret_valid),
        .data_ret_valid  (data_ret_valid),
        .ret_block       (ret_block),
        .mem_response    (mem_response),
        .mem_tag         (mem_tag),
        .mem_data_in     (mem_data_in),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_data        (mem_data)
    );

endmodule

/* tests/mem_front_asserts.sv */
`timescale 1ns/100ps
`include "mem_front_config.svh"

module mem_front_asserts (
    input logic                        clock,
    input logic                        reset,
    input logic                        inst_valid,
    input logic                        inst_ready,
    input logic [`MF_XLEN-1:0]         inst,
    input logic [`MF_XLEN-1:0]         inst_pc,
    input logic                        load_valid,
    input logic                        load_ready,
    input mem_front_pkg::mem_block_t   load_data,
    input logic [`MF_ID_BITS-1:0]      load_id,
    input logic                        fetch_req_valid,
    input logic                        fetch_req_ready,
    input logic                        data_req_valid,
    input mem_front_pkg::bus_command_t data_command,
    input logic [`MF_XLEN-1:0]         data_addr,
    input mem_front_pkg::bus_command_t mem_command,
    input logic [`MF_XLEN-1:0]         mem_addr,
    input logic [`MF_TAG_BITS-1:0]     mem_tag,
    input logic                        fetch_ret_valid,
    input logic                        data_ret_valid
);

    // assertion failures so far
    int fail_count = 0;

    ////////////////////////////////////////
    // reset and command rules
    ////////////////////////////////////////
    a_reset_quiet: assert property (@(posedge clock) reset |-> !inst_valid && !load_valid)
        else begin $error("valid output high during reset"); fail_count++; end

    // memory port idle while in reset
    a_reset_port: assert property (@(posedge clock)
        reset |-> mem_command == mem_front_pkg::BUS_NONE
                  && !fetch_req_valid && !data_req_valid)
        else begin $error("memory port active during reset"); fail_count++; end

    ////////////////////////////////////////
    // arbitration and returns
    ////////////////////////////////////////
    a_data_wins: assert property (@(posedge clock) disable iff (reset)
        data_req_valid |-> !fetch_req_ready && mem_addr == data_addr
                           && mem_command == data_command)
        else begin $error("data request not routed to memory"); fail_count++; end

    // every returned tag was recorded for a requester
    a_ret_owned: assert property (@(posedge clock) disable iff (reset)
        mem_tag != '0 |-> fetch_ret_valid || data_ret_valid)
        else begin $error("returned tag has no recorded owner"); fail_count++; end

    // payload frozen under back-pressure
    a_inst_hold: assert property (@(posedge clock) disable iff (reset)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc))
        else begin $error("instruction changed while stalled"); fail_count++; end

    a_load_hold: assert property (@(posedge clock) disable iff (reset)
        load_valid && !load_ready |=> load_valid && $stable(load_data) && $stable(load_id))
        else begin $error("load result changed while stalled"); fail_count++; end

endmodule

bind mem_front_top mem_front_asserts i_asserts (.*);

/* tests/mem_front_tb.sv */
`timescale 1ns/100ps
`include "mem_front_config.svh"

module mem_front_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int N_INST       = 24;
    // phase a mixed traffic, phase b fills the queue
    localparam int N_PHASE_A    = 12;
    localparam int N_REQ        = N_PHASE_A + `MF_LSQ_DEPTH + 2;
    // worst case cycles per item, rejections included
    localparam int WORST_CYCLES = 40;
    localparam logic [`MF_XLEN-1:0] DATA_BASE = 32'h0000_0400;

    logic                        clock;
    logic                        reset;
    logic [`MF_TAG_BITS-1:0]     mem_response;
    logic [`MF_TAG_BITS-1:0]     mem_tag;
    mem_front_pkg::mem_block_t   mem_data_in;
    mem_front_pkg::bus_command_t mem_command;
    logic [`MF_XLEN-1:0]         mem_addr;
    mem_front_pkg::mem_block_t   mem_data;
    logic                        inst_valid;
    logic                        inst_ready;
    logic [`MF_XLEN-1:0]         inst;
    logic [`MF_XLEN-1:0]         inst_pc;
    logic                        req_valid;
    logic                        req_ready;
    logic                        req_store;
    logic [`MF_XLEN-1:0]         req_addr;
    mem_front_pkg::mem_block_t   req_data;
    logic [`MF_ID_BITS-1:0]      req_id;
    logic                        load_valid;
    logic                        load_ready;
    mem_front_pkg::mem_block_t   load_data;
    logic [`MF_ID_BITS-1:0]      load_id;

    mem_front_top i_dut (.*);

    ////////////////////////////////////////
    // memory model and scoreboards
    ////////////////////////////////////////
    mem_front_pkg::mem_block_t model_mem [256];
    // program-order view, what each load must see
    mem_front_pkg::mem_block_t shadow    [256];
    logic                      pend_valid [`MF_NUM_TAGS];
    int                        pend_due   [`MF_NUM_TAGS];
    mem_front_pkg::mem_block_t pend_data  [`MF_NUM_TAGS];
    logic [`MF_TAG_BITS-1:0]   next_tag;
    logic [15:0]               lfsr;
    int                        cycle;
    int                        errors;
    int                        n_inst;
    int                        req_idx;
    int                        b_acc;
    logic                      full_seen;
    logic [`MF_XLEN-1:0]       exp_pc;
    logic                      scr_store [N_REQ];
    logic [`MF_XLEN-1:0]       scr_addr  [N_REQ];
    logic [`MF_ID_BITS-1:0]    exp_id    [$];
    mem_front_pkg::mem_block_t exp_data  [$];

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    // instruction word at any byte address
    function automatic logic [`MF_XLEN-1:0] word_init(input logic [`MF_XLEN-1:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic mem_front_pkg::mem_block_t block_init(input logic [`MF_XLEN-1:0] a);
        mem_front_pkg::mem_block_t b;
        b.words[0] = word_init({a[`MF_XLEN-1:3], 3'b000});
        b.words[1] = word_init({a[`MF_XLEN-1:3], 3'b100});
        return b;
    endfunction

    function automatic mem_front_pkg::mem_block_t store_value(input int i);
        mem_front_pkg::mem_block_t b;
        b.dword = {32'hD00D_0000 + i, ~(32'h0000_0100 * i)};
        return b;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // per-cycle work on the falling edge
    ////////////////////////////////////////

    // one tag back per cycle, then answer the current command
    task automatic serve_memory();
        logic       b;
        logic [1:0] d;
        mem_tag     = '0;
        mem_data_in = '0;
        for (int t = 1; t < `MF_NUM_TAGS; t++) begin
            if (pend_valid[t] && pend_due[t] <= cycle && mem_tag == '0) begin
                mem_tag       = `MF_TAG_BITS'(t);
                mem_data_in   = pend_data[t];
                pend_valid[t] = 1'b0;
            end
        end
        mem_response = '0;
        if (mem_command != mem_front_pkg::BUS_NONE) begin
            take_bit(b);
            if (!b) begin
                mem_response = next_tag;
                next_tag = (next_tag == `MF_TAG_BITS'(`MF_NUM_TAGS - 1)) ?
                           `MF_TAG_BITS'(1) : next_tag + 1'b1;
                if (mem_command == mem_front_pkg::BUS_STORE) begin
                    model_mem[mem_addr[10:3]] = mem_data;
                end else begin
                    // 1 to 4 cycles later
                    take_bit(d[0]);
                    take_bit(d[1]);
                    pend_valid[mem_response] = 1'b1;
                    pend_due[mem_response]   = cycle + 1 + d;
                    pend_data[mem_response]  = model_mem[mem_addr[10:3]];
                end
            end
        end
    endtask

    task automatic drive_inputs();
        logic b;
        take_bit(b);
        inst_ready = (n_inst < N_INST) && b;
        // loads held back in phase b until the queue is full
        take_bit(b);
        load_ready = b && !(b_acc != 0 && !full_seen);
        req_valid  = 1'b0;
        // phase b starts from an empty queue
        if (req_idx < N_REQ && (req_idx != N_PHASE_A || exp_id.size() == 0)) begin
            req_valid = 1'b1;
            req_store = scr_store[req_idx];
            req_addr  = scr_addr[req_idx];
            req_data  = store_value(req_idx);
            req_id    = `MF_ID_BITS'(req_idx);
        end
    endtask

    // handshakes that complete on the coming rising edge
    task automatic observe_handshakes();
        if (b_acc == `MF_LSQ_DEPTH && !full_seen) begin
            check_value("full_queue", 64'h0, req_ready);
            full_seen = 1'b1;
        end
        if (inst_valid && inst_ready) begin
            check_value("inst_stream_pc", exp_pc, inst_pc);
            check_value("inst_stream_word", word_init(exp_pc), inst);
            exp_pc = exp_pc + 4;
            n_inst++;
        end
        if (req_valid && req_ready) begin
            if (req_store) begin
                shadow[req_addr[10:3]] = req_data;
            end else begin
                exp_id.push_back(req_id);
                exp_data.push_back(shadow[req_addr[10:3]]);
            end
            if (req_idx >= N_PHASE_A) begin
                b_acc++;
            end
            req_idx++;
        end
        if (load_valid && load_ready) begin
            assert (exp_id.size() != 0) else begin
                errors++;
                $display("load result with id %0d arrived with no load outstanding", load_id);
            end
            if (exp_id.size() != 0) begin
                check_value("load_id", exp_id.pop_front(), load_id);
                check_value("load_data", exp_data.pop_front(), load_data.dword);
            end
        end
    endtask

    ////////////////////////////////////////
    // clock, watchdog, main sequence
    ////////////////////////////////////////
    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(CLK_PERIOD * (N_REQ + N_INST) * WORST_CYCLES);
        $display("watchdog expired before all instructions and loads completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic b0;
        logic k0;
        logic k1;
        reset        = 1'b1;
        mem_response = '0;
        mem_tag      = '0;
        mem_data_in  = '0;
        inst_ready   = 1'b0;
        req_valid    = 1'b0;
        req_store    = 1'b0;
        req_addr     = '0;
        req_data     = '0;
        req_id       = '0;
        load_ready   = 1'b0;
        lfsr         = 16'd12;
        next_tag     = `MF_TAG_BITS'(1);
        cycle        = 0;
        errors       = 0;
        n_inst       = 0;
        req_idx      = 0;
        b_acc        = 0;
        full_seen    = 1'b0;
        exp_pc       = `MF_RESET_PC;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = block_init(i * 8);
            shadow[i]    = model_mem[i];
        end
        for (int t = 0; t < `MF_NUM_TAGS; t++) begin
            pend_valid[t] = 1'b0;
        end
        // four shared blocks, last phase a request a load
        for (int i = 0; i < N_REQ; i++) begin
            take_bit(b0);
            take_bit(k0);
            take_bit(k1);
            scr_store[i] = (i < N_PHASE_A - 1) && b0;
            scr_addr[i]  = DATA_BASE + 8 * {k1, k0};
        end
        repeat (3) @(negedge clock);
        check_value("reset_state", 64'h0, {inst_valid, load_valid});
        check_value("reset_state", 64'h1, req_ready);
        reset = 1'b0;
        while (!(req_idx == N_REQ && exp_id.size() == 0 && n_inst == N_INST)) begin
            @(negedge clock);
            cycle++;
            serve_memory();
            drive_inputs();
            #1;
            observe_handshakes();
        end
        $display("closing counts: %0d check errors, %0d assertion errors",
                 errors, i_dut.i_asserts.fail_count);
        if (errors == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/mem_front_pkg.sv
hdl/fetch_unit.sv
lsq/lsq.sv
hdl/mem_arbiter.sv
hdl/mem_front_top.sv
tests/mem_front_asserts.sv
tests/mem_front_tb.sv
